// ==== hazardPipe.f ====
mipsIsaPkg.sv
hazardPkg.sv
instrDecode.sv
operandDemand.sv
resultSupply.sv
hazardUnit.sv
hazardPipe.sv
hazardPipe_props.sv
hazardPipeTb.sv

// ==== hazardPipe.sv ====
`timescale 1ns/100ps

module hazardPipe #(
    parameter logic [mipsIsaPkg::regAddrWidth-1:0] linkReg = hazardPkg::defaultLinkReg
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mipsIsaPkg::instrWidth-1:0] fetchInstr,
    input  logic                              linkTaken,
    output logic                              fetchEnable,
    output logic [mipsIsaPkg::instrWidth-1:0] decodeInstr,
    output logic [mipsIsaPkg::instrWidth-1:0] retireInstr
);

    logic                                stall;

    // Demand side to hazard unit
    logic [mipsIsaPkg::regAddrWidth-1:0] decodeRs;
    logic [mipsIsaPkg::regAddrWidth-1:0] decodeRt;
    hazardPkg::stageTimeT                tuseRs;
    hazardPkg::stageTimeT                tuseRt;

    // Supply side to hazard unit
    logic [mipsIsaPkg::regAddrWidth-1:0] execDest;
    hazardPkg::stageTimeT                execTnew;
    logic [mipsIsaPkg::regAddrWidth-1:0] memDest;
    hazardPkg::stageTimeT                memTnew;

    ////////////////////////////////
    // Decode side
    ////////////////////////////////

    operandDemand #(
        .linkReg     (linkReg)
    ) demand (
        .clk         (clk),
        .reset       (reset),
        .fetchInstr  (fetchInstr),
        .stall       (stall),
        .decodeInstr (decodeInstr),
        .decodeRs    (decodeRs),
        .decodeRt    (decodeRt),
        .tuseRs      (tuseRs),
        .tuseRt      (tuseRt)
    );

    ////////////////////////////////
    // Back end
    ////////////////////////////////

    resultSupply #(
        .linkReg     (linkReg)
    ) supply (
        .clk         (clk),
        .reset       (reset),
        .decodeInstr (decodeInstr),
        .stall       (stall),
        .linkTaken   (linkTaken),
        .execDest    (execDest),
        .execTnew    (execTnew),
        .memDest     (memDest),
        .memTnew     (memTnew),
        .retireInstr (retireInstr)
    );

    hazardUnit hazard (
        .decodeRs    (decodeRs),
        .decodeRt    (decodeRt),
        .tuseRs      (tuseRs),
        .tuseRt      (tuseRt),
        .execDest    (execDest),
        .execTnew    (execTnew),
        .memDest     (memDest),
        .memTnew     (memTnew),
        .stall       (stall)
    );

    // Fetch advances whenever decode is free
    assign fetchEnable = !stall;

endmodule

// ==== hazardPipeTb.sv ====
`timescale 1ns/100ps

module hazardPipeTb;

    typedef logic [mipsIsaPkg::instrWidth-1:0]   wordT;
    typedef logic [mipsIsaPkg::regAddrWidth-1:0] regT;

    // Reference model instruction classes
    typedef enum {
        clsNop, clsCalcR, clsOri, clsLui, clsLw, clsSw, clsBeq, clsBgtz, clsJr, clsBpnal
    } clsT;

    localparam int  numInstr    = 2000;
    localparam int  resetCycles = 10;
    // At most two stall cycles per instruction
    localparam int  cycleLimit  = 3 * numInstr + resetCycles;
    localparam regT linkReg     = 5'd31;

    logic clk;
    logic reset;
    wordT fetchInstr;
    logic linkTaken;
    logic fetchEnable;
    wordT decodeInstr;
    wordT retireInstr;

    logic [15:0] lfsrState = 16'd17996;

    // Reference pipeline
    wordT modelDecode;
    wordT modelExec;
    wordT modelMem;
    wordT modelRetire;
    logic modelMemLink;
    logic modelStallNow;

    // Issue order and bookkeeping
    wordT issuedQ[$];
    logic fetchReal;
    logic prevHeld;
    wordT prevDecode;
    int   issued;
    int   retired;
    int   errors;
    int   checks;
    int   stallCycles;
    int   cycleCount;

    hazardPipe #(
        .linkReg     (linkReg)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .fetchInstr  (fetchInstr),
        .linkTaken   (linkTaken),
        .fetchEnable (fetchEnable),
        .decodeInstr (decodeInstr),
        .retireInstr (retireInstr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////
    // Random stimulus
    //////////////////////////////

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        bits = 8'd0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[6:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // Mostly 0 to 3 and now and then the link register
    function automatic regT pickReg();
        logic [2:0] sel;
        sel = 3'(takeBits(3));
        return (sel == 3'd7) ? linkReg : {3'b000, sel[1:0]};
    endfunction

    function automatic wordT makeInstr();
        logic [3:0]  kind;
        regT         rs;
        regT         rt;
        regT         rd;
        logic [15:0] imm;
        wordT        w;
        kind = 4'(takeBits(4));
        rs   = pickReg();
        rt   = pickReg();
        rd   = pickReg();
        imm  = {8'd0, takeBits(8)};
        // Loads and branches weighted up
        case (kind)
            4'd0, 4'd13:       w = {mipsIsaPkg::special, rs, rt, rd, 5'd0, mipsIsaPkg::addu};
            4'd1:              w = {mipsIsaPkg::special, rs, rt, rd, 5'd0, mipsIsaPkg::subu};
            4'd2:              w = {mipsIsaPkg::ori, rs, rt, imm};
            4'd3:              w = {mipsIsaPkg::lui, 5'd0, rt, imm};
            4'd4, 4'd11, 4'd12: w = {mipsIsaPkg::lw, rs, rt, imm};
            4'd5:              w = {mipsIsaPkg::sw, rs, rt, imm};
            4'd6:              w = {mipsIsaPkg::beq, rs, rt, imm};
            4'd7:              w = {mipsIsaPkg::bgtz, rs, 5'd0, imm};
            4'd8:              w = {mipsIsaPkg::special, rs, 15'd0, mipsIsaPkg::jr};
            4'd9, 4'd14:       w = {mipsIsaPkg::bpnal, rs, 5'd0, imm};
            // Shift by one is a nop with a nonzero word
            default:           w = {6'd0, 5'd0, rt, rd, 5'd1, 6'd0};
        endcase
        return w;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic clsT classOf(input wordT w);
        case (w[31:26])
            mipsIsaPkg::special: begin
                if (w[5:0] == mipsIsaPkg::addu || w[5:0] == mipsIsaPkg::subu) begin
                    return clsCalcR;
                end
                return (w[5:0] == mipsIsaPkg::jr) ? clsJr : clsNop;
            end
            mipsIsaPkg::ori:   return clsOri;
            mipsIsaPkg::lui:   return clsLui;
            mipsIsaPkg::lw:    return clsLw;
            mipsIsaPkg::sw:    return clsSw;
            mipsIsaPkg::beq:   return clsBeq;
            mipsIsaPkg::bgtz:  return clsBgtz;
            mipsIsaPkg::bpnal: return clsBpnal;
            default:           return clsNop;
        endcase
    endfunction

    // Cycles until the decode instruction needs rs or rt
    function automatic hazardPkg::stageTimeT tuseOf(input wordT w, input logic forRt);
        clsT cls;
        cls = classOf(w);
        if (!forRt) begin
            case (cls)
                clsBeq, clsBgtz, clsJr, clsBpnal: return 2'd0;
                clsCalcR, clsOri, clsLw, clsSw:   return 2'd1;
                default:                          return 2'd3;
            endcase
        end
        case (cls)
            clsBeq, clsBgtz: return 2'd0;
            clsCalcR:        return 2'd1;
            clsSw:           return 2'd2;
            default:         return 2'd3;
        endcase
    endfunction

    // Cycles until the result can be forwarded
    function automatic hazardPkg::stageTimeT tnewOf(input wordT w, input logic inMem);
        clsT cls;
        cls = classOf(w);
        if (inMem) begin
            return (cls == clsLw) ? 2'd1 : 2'd0;
        end
        case (cls)
            clsCalcR, clsOri, clsLui: return 2'd1;
            clsLw:                    return 2'd2;
            default:                  return 2'd0;
        endcase
    endfunction

    function automatic regT destOf(input wordT w, input logic taken);
        case (classOf(w))
            clsCalcR:              return w[15:11];
            clsOri, clsLui, clsLw: return w[20:16];
            clsBpnal:              return taken ? linkReg : 5'd0;
            default:               return 5'd0;
        endcase
    endfunction

    // Any source needed before its producer is ready
    function automatic logic modelStall(input wordT dec, input wordT ex, input wordT mem,
                                        input logic exLink, input logic memLink);
        regT                  src  [2];
        regT                  dest [2];
        hazardPkg::stageTimeT tuse [2];
        hazardPkg::stageTimeT tnew [2];
        logic                 hit;
        src[0]  = dec[25:21];
        src[1]  = dec[20:16];
        tuse[0] = tuseOf(dec, 1'b0);
        tuse[1] = tuseOf(dec, 1'b1);
        dest[0] = destOf(ex, exLink);
        dest[1] = destOf(mem, memLink);
        tnew[0] = tnewOf(ex, 1'b0);
        tnew[1] = tnewOf(mem, 1'b1);
        hit = 1'b0;
        for (int s = 0; s < 2; s++) begin
            for (int d = 0; d < 2; d++) begin
                if (src[s] != 5'd0 && src[s] == dest[d] && tuse[s] < tnew[d]) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // Timeout
    //////////////////////////////

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                 cycleCount, retired, numInstr);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset        = 1'b1;
        fetchInstr   = mipsIsaPkg::nopInstr;
        linkTaken    = 1'b0;
        fetchReal    = 1'b0;
        modelDecode  = mipsIsaPkg::nopInstr;
        modelExec    = mipsIsaPkg::nopInstr;
        modelMem     = mipsIsaPkg::nopInstr;
        modelRetire  = mipsIsaPkg::nopInstr;
        modelMemLink = 1'b0;
        prevHeld     = 1'b0;
        prevDecode   = mipsIsaPkg::nopInstr;
        issued       = 0;
        retired      = 0;
        errors       = 0;
        checks       = 0;
        stallCycles  = 0;
        repeat (resetCycles) @(posedge clk);
        #10;
        // Pipeline empty out of reset
        checkBit("fetchEnable", fetchEnable, 1'b1);
        checkWord("decodeInstr", decodeInstr, mipsIsaPkg::nopInstr);
        checkWord("retireInstr", retireInstr, mipsIsaPkg::nopInstr);
        reset      = 1'b0;
        fetchInstr = makeInstr();
        fetchReal  = 1'b1;
        linkTaken  = takeBits(1) != 8'd0;
        while (retired < numInstr) begin
            // Mid cycle where inputs and registers have settled
            @(negedge clk);
            modelStallNow = modelStall(modelDecode, modelExec, modelMem, linkTaken, modelMemLink);
            if (modelStallNow) begin
                stallCycles++;
            end
            checkBit("fetchEnable", fetchEnable, !modelStallNow);
            checkWord("decodeInstr", decodeInstr, modelDecode);
            checkWord("retireInstr", retireInstr, modelRetire);
            if (prevHeld) begin
                checkWord("decodeInstr", decodeInstr, prevDecode);
            end
            prevHeld   = modelStallNow;
            prevDecode = modelDecode;
            // In-order retirement against the issue queue
            if (retireInstr !== mipsIsaPkg::nopInstr) begin
                if (issuedQ.size() == 0) begin
                    errors++;
                    $display("ERROR %0t retireInstr shows %h, which was never issued",
                             $time, retireInstr);
                end else begin
                    checkWord("retireInstr", retireInstr, issuedQ.pop_front());
                end
                retired++;
            end
            @(posedge clk);
            modelRetire  = modelMem;
            modelMem     = modelExec;
            modelMemLink = linkTaken;
            if (modelStallNow) begin
                modelExec = mipsIsaPkg::nopInstr;
            end else begin
                modelExec   = modelDecode;
                modelDecode = fetchInstr;
                if (fetchReal) begin
                    issuedQ.push_back(fetchInstr);
                    issued++;
                end
            end
            #10;
            // New word only once the last one was taken
            if (!modelStallNow) begin
                fetchReal  = issued < numInstr;
                fetchInstr = fetchReal ? makeInstr() : mipsIsaPkg::nopInstr;
            end
            linkTaken = takeBits(1) != 8'd0;
        end
        $display("Checks %0d, errors %0d, assertion failures %0d, stall cycles %0d",
                 checks, errors, DUT.props.failCount, stallCycles);
        if (errors == 0 && DUT.props.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hazardPipe_props.sv ====
`timescale 1ns/100ps

module hazardPipeProps (
    input logic                              clk,
    input logic                              reset,
    input logic                              stall,
    input logic                              fetchEnable,
    input logic [mipsIsaPkg::instrWidth-1:0] decodeInstr,
    input hazardPkg::stageTimeT              execTnew,
    input hazardPkg::stageTimeT              memTnew
);

    // Failure tally for the closing summary
    int failCount = 0;

    //////////////////////////////
    // Stall behavior
    //////////////////////////////

    // Second stall cycle only while a load sits in memory
    assertLongStall: assert property (@(posedge clk) disable iff (reset)
        (stall && $past(stall)) |-> (memTnew == hazardPkg::tnewOne)) else begin
        failCount++;
        $error("Two-cycle stall without a load in memory");
    end

    // Decode holds its word
    assertDecodeHeld: assert property (@(posedge clk) disable iff (reset)
        stall |=> (decodeInstr == $past(decodeInstr))) else begin
        failCount++;
        $error("Decode register changed during a stall");
    end

    // Bubble has no result
    assertBubble: assert property (@(posedge clk) disable iff (reset)
        stall |=> (execTnew == hazardPkg::tnewReady)) else begin
        failCount++;
        $error("Execute did not receive a bubble after a stall");
    end

    // From the second reset edge on
    assertResetFetch: assert property (@(posedge clk)
        reset |=> fetchEnable) else begin
        failCount++;
        $error("Fetch was disabled during reset");
    end

endmodule

bind hazardPipe hazardPipeProps props (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .fetchEnable (fetchEnable),
    .decodeInstr (decodeInstr),
    .execTnew    (execTnew),
    .memTnew     (memTnew)
);

// ==== hazardPkg.sv ====
package hazardPkg;

    ////////////////////////////////
    // Stage timing
    ////////////////////////////////

    // Cycle count until a value is needed or produced
    typedef logic [1:0] stageTimeT;

    // Tuse values
    // Cycles after decode until the operand is consumed
    localparam stageTimeT tuseImmediate = 2'd0;
    localparam stageTimeT tuseNext      = 2'd1;
    localparam stageTimeT tuseLater     = 2'd2;
    // Operand never read so larger than any Tnew
    localparam stageTimeT tuseNever     = 2'd3;

    // Tnew values
    // Cycles until the result can be forwarded
    localparam stageTimeT tnewReady = 2'd0;
    localparam stageTimeT tnewOne   = 2'd1;
    localparam stageTimeT tnewTwo   = 2'd2;

    ////////////////////////////////
    // Link register
    ////////////////////////////////

    // ra in the usual register convention
    localparam logic [mipsIsaPkg::regAddrWidth-1:0] defaultLinkReg = 5'd31;

endpackage

// ==== hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  logic [mipsIsaPkg::regAddrWidth-1:0] decodeRs,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] decodeRt,
    input  hazardPkg::stageTimeT                tuseRs,
    input  hazardPkg::stageTimeT                tuseRt,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] execDest,
    input  hazardPkg::stageTimeT                execTnew,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] memDest,
    input  hazardPkg::stageTimeT                memTnew,
    output logic                                stall
);

    // Per source and per stage
    logic rsExecHit;
    logic rsMemHit;
    logic rtExecHit;
    logic rtMemHit;

    ////////////////////////////////
    // Single comparison
    ////////////////////////////////

    // Result arrives too late even with forwarding
    function automatic logic lateResult(
        input logic [mipsIsaPkg::regAddrWidth-1:0] src,
        input hazardPkg::stageTimeT                tuse,
        input logic [mipsIsaPkg::regAddrWidth-1:0] dest,
        input hazardPkg::stageTimeT                tnew
    );
        // Register 0 is hardwired and never waits
        return (src != '0) && (src == dest) && (tuse < tnew);
    endfunction

    ////////////////////////////////
    // Demand against supply
    ////////////////////////////////

    assign rsExecHit = lateResult(decodeRs, tuseRs, execDest, execTnew);
    assign rsMemHit  = lateResult(decodeRs, tuseRs, memDest, memTnew);
    assign rtExecHit = lateResult(decodeRt, tuseRt, execDest, execTnew);
    assign rtMemHit  = lateResult(decodeRt, tuseRt, memDest, memTnew);

    // Any late source holds the front end
    assign stall = rsExecHit | rsMemHit | rtExecHit | rtMemHit;

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/100ps

module instrDecode #(
    parameter logic [mipsIsaPkg::regAddrWidth-1:0] linkReg = hazardPkg::defaultLinkReg
) (
    input  logic [mipsIsaPkg::instrWidth-1:0]   instr,
    output logic [mipsIsaPkg::regAddrWidth-1:0] rs,
    output logic [mipsIsaPkg::regAddrWidth-1:0] rt,
    output hazardPkg::stageTimeT                tuseRs,
    output hazardPkg::stageTimeT                tuseRt,
    output hazardPkg::stageTimeT                tnewExec,
    output hazardPkg::stageTimeT                tnewMem,
    output logic                                writesLink,
    output logic [mipsIsaPkg::regAddrWidth-1:0] dest
);

    mipsIsaPkg::opcodeT                  opcode;
    mipsIsaPkg::functT                   funct;
    logic [mipsIsaPkg::regAddrWidth-1:0] rd;

    // One flag per instruction class
    logic calcR;
    logic calcI;
    logic isLui;
    logic isLoad;
    logic isStore;
    logic isBeq;
    logic isBgtz;
    logic isJr;
    logic isBpnal;

    ////////////////////////////////
    // Field extraction
    ////////////////////////////////

    assign opcode = mipsIsaPkg::opcodeT'(instr[mipsIsaPkg::opcodeLsb +: mipsIsaPkg::opcodeWidth]);
    assign funct  = mipsIsaPkg::functT'(instr[mipsIsaPkg::functLsb +: mipsIsaPkg::functWidth]);
    assign rs     = instr[mipsIsaPkg::rsLsb +: mipsIsaPkg::regAddrWidth];
    assign rt     = instr[mipsIsaPkg::rtLsb +: mipsIsaPkg::regAddrWidth];
    assign rd     = instr[mipsIsaPkg::rdLsb +: mipsIsaPkg::regAddrWidth];

    ////////////////////////////////
    // Classification
    ////////////////////////////////

    always_comb begin
        calcR   = 1'b0;
        calcI   = 1'b0;
        isLui   = 1'b0;
        isLoad  = 1'b0;
        isStore = 1'b0;
        isBeq   = 1'b0;
        isBgtz  = 1'b0;
        isJr    = 1'b0;
        isBpnal = 1'b0;
        // Unlisted encodings keep every flag low and act as nop
        case (opcode)
            mipsIsaPkg::special: begin
                case (funct)
                    mipsIsaPkg::addu: calcR = 1'b1;
                    mipsIsaPkg::subu: calcR = 1'b1;
                    mipsIsaPkg::jr:   isJr  = 1'b1;
                    default:          calcR = 1'b0;
                endcase
            end
            mipsIsaPkg::ori:   calcI   = 1'b1;
            mipsIsaPkg::lui:   isLui   = 1'b1;
            mipsIsaPkg::lw:    isLoad  = 1'b1;
            mipsIsaPkg::sw:    isStore = 1'b1;
            mipsIsaPkg::beq:   isBeq   = 1'b1;
            mipsIsaPkg::bgtz:  isBgtz  = 1'b1;
            mipsIsaPkg::bpnal: isBpnal = 1'b1;
            default:           calcR   = 1'b0;
        endcase
    end

    ////////////////////////////////
    // Tuse of both sources
    ////////////////////////////////

    // Branch compares happen in decode itself
    assign tuseRs = (isBeq | isBgtz | isJr | isBpnal)            ? hazardPkg::tuseImmediate :
                    (calcR | calcI | isLoad | isStore)           ? hazardPkg::tuseNext :
                                                                   hazardPkg::tuseNever;

    // Store data is only needed in memory
    assign tuseRt = (isBeq | isBgtz) ? hazardPkg::tuseImmediate :
                    calcR            ? hazardPkg::tuseNext :
                    isStore          ? hazardPkg::tuseLater :
                                       hazardPkg::tuseNever;

    ////////////////////////////////
    // Tnew and destination
    ////////////////////////////////

    // Seen from the execute register
    assign tnewExec = (calcR | calcI | isLui) ? hazardPkg::tnewOne :
                      isLoad                  ? hazardPkg::tnewTwo :
                                                hazardPkg::tnewReady;

    // Only a load still has work left after memory entry
    assign tnewMem = isLoad ? hazardPkg::tnewOne : hazardPkg::tnewReady;

    // Link condition is applied by the caller
    assign writesLink = isBpnal;

    assign dest = calcR                     ? rd :
                  (calcI | isLui | isLoad)  ? rt :
                  isBpnal                   ? linkReg :
                                              '0;

endmodule

// ==== mipsIsaPkg.sv ====
package mipsIsaPkg;

    ////////////////////////////////
    // Word and field widths
    ////////////////////////////////

    localparam int instrWidth   = 32;
    localparam int opcodeWidth  = 6;
    localparam int functWidth   = 6;
    localparam int regAddrWidth = 5;

    // Lowest bit of each field in the word
    localparam int opcodeLsb = 26;
    localparam int rsLsb     = 21;
    localparam int rtLsb     = 16;
    localparam int rdLsb     = 11;
    localparam int functLsb  = 0;

    ////////////////////////////////
    // Encodings
    ////////////////////////////////

    // Primary opcode in bits 31..26
    typedef enum logic [opcodeWidth-1:0] {
        special = 6'b000000,
        beq     = 6'b000100,
        bgtz    = 6'b000111,
        ori     = 6'b001101,
        lui     = 6'b001111,
        bpnal   = 6'b110011,
        lw      = 6'b100011,
        sw      = 6'b101011
    } opcodeT;

    // Funct field of the special group
    typedef enum logic [functWidth-1:0] {
        jr   = 6'b001000,
        addu = 6'b100001,
        subu = 6'b100011
    } functT;

    // All zero word for reset and bubbles
    localparam logic [instrWidth-1:0] nopInstr = '0;

endpackage

// ==== operandDemand.sv ====
`timescale 1ns/100ps

module operandDemand #(
    parameter logic [mipsIsaPkg::regAddrWidth-1:0] linkReg = hazardPkg::defaultLinkReg
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mipsIsaPkg::instrWidth-1:0]   fetchInstr,
    input  logic                                stall,
    output logic [mipsIsaPkg::instrWidth-1:0]   decodeInstr,
    output logic [mipsIsaPkg::regAddrWidth-1:0] decodeRs,
    output logic [mipsIsaPkg::regAddrWidth-1:0] decodeRt,
    output hazardPkg::stageTimeT                tuseRs,
    output hazardPkg::stageTimeT                tuseRt
);

    ////////////////////////////////
    // Decode register
    ////////////////////////////////

    // Holds under stall so the consumer waits in decode
    always_ff @(posedge clk) begin
        if (reset) begin
            decodeInstr <= mipsIsaPkg::nopInstr;
        end else if (!stall) begin
            decodeInstr <= fetchInstr;
        end
    end

    ////////////////////////////////
    // Source demand
    ////////////////////////////////

    // Only the reading side of the decoder matters here
    instrDecode #(
        .linkReg    (linkReg)
    ) decodeClassify (
        .instr      (decodeInstr),
        .rs         (decodeRs),
        .rt         (decodeRt),
        .tuseRs     (tuseRs),
        .tuseRt     (tuseRt),
        .tnewExec   (),
        .tnewMem    (),
        .writesLink (),
        .dest       ()
    );

endmodule

// ==== resultSupply.sv ====
`timescale 1ns/100ps

module resultSupply #(
    parameter logic [mipsIsaPkg::regAddrWidth-1:0] linkReg = hazardPkg::defaultLinkReg
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mipsIsaPkg::instrWidth-1:0]   decodeInstr,
    input  logic                                stall,
    input  logic                                linkTaken,
    output logic [mipsIsaPkg::regAddrWidth-1:0] execDest,
    output hazardPkg::stageTimeT                execTnew,
    output logic [mipsIsaPkg::regAddrWidth-1:0] memDest,
    output hazardPkg::stageTimeT                memTnew,
    output logic [mipsIsaPkg::instrWidth-1:0]   retireInstr
);

    logic [mipsIsaPkg::instrWidth-1:0]   execInstr;
    logic [mipsIsaPkg::instrWidth-1:0]   memInstr;
    // Link condition captured as the instruction leaves execute
    logic                                memLinkTaken;

    // Raw decoder results before the link condition
    logic [mipsIsaPkg::regAddrWidth-1:0] execDestRaw;
    logic [mipsIsaPkg::regAddrWidth-1:0] memDestRaw;
    logic                                execIsLink;
    logic                                memIsLink;

    ////////////////////////////////
    // Execute, memory, writeback
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            execInstr    <= mipsIsaPkg::nopInstr;
            memInstr     <= mipsIsaPkg::nopInstr;
            retireInstr  <= mipsIsaPkg::nopInstr;
            memLinkTaken <= 1'b0;
        end else begin
            // Bubble into execute while decode is held
            if (stall) begin
                execInstr <= mipsIsaPkg::nopInstr;
            end else begin
                execInstr <= decodeInstr;
            end
            // Later stages never wait
            memInstr     <= execInstr;
            memLinkTaken <= linkTaken;
            retireInstr  <= memInstr;
        end
    end

    ////////////////////////////////
    // Execute stage supply
    ////////////////////////////////

    instrDecode #(
        .linkReg    (linkReg)
    ) execClassify (
        .instr      (execInstr),
        .rs         (),
        .rt         (),
        .tuseRs     (),
        .tuseRt     (),
        .tnewExec   (execTnew),
        .tnewMem    (),
        .writesLink (execIsLink),
        .dest       (execDestRaw)
    );

    // Live condition from the execute datapath
    assign execDest = (execIsLink && !linkTaken) ? '0 : execDestRaw;

    ////////////////////////////////
    // Memory stage supply
    ////////////////////////////////

    instrDecode #(
        .linkReg    (linkReg)
    ) memClassify (
        .instr      (memInstr),
        .rs         (),
        .rt         (),
        .tuseRs     (),
        .tuseRt     (),
        .tnewExec   (),
        .tnewMem    (memTnew),
        .writesLink (memIsLink),
        .dest       (memDestRaw)
    );

    // Stored condition travels with the instruction
    assign memDest = (memIsLink && !memLinkTaken) ? '0 : memDestRaw;

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the hazardPipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hazardPipeTb \
    -f hazardPipe.f -o hazardPipeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let every assertion failure through so the testbench can count them
output=$(./obj_dir/hazardPipeSim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
